// ==== common/ncpu_config.svh ====
`ifndef NCPU_CONFIG_SVH
`define NCPU_CONFIG_SVH

// Data path width
`define NCPU_DW         64

// Physical register file, 64 entries
`define NCPU_PRF_AW     6

// Reorder buffer id
`define NCPU_ROB_AW     5

`define NCPU_IQ_DEPTH   4

`define NCPU_ALU_OPW    3

`endif

// ==== common/ncpu_isa_pkg.sv ====
`include "ncpu_config.svh"

package ncpu_isa_pkg;

   // ALU operations
   typedef enum logic [`NCPU_ALU_OPW-1:0]
   {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      // Shift amount from low bits of operand 2
      ALU_SLL = 3'd5,
      ALU_SRL = 3'd6,
      // Signed compare, result is 1 or 0
      ALU_SLT = 3'd7
   } alu_opc_t;

   // Operand and result word
   typedef logic [`NCPU_DW-1:0] dword_t;

endpackage

// ==== common/ncpu_pipe_pkg.sv ====
`include "ncpu_config.svh"

package ncpu_pipe_pkg;

   // Physical register number
   typedef logic [`NCPU_PRF_AW-1:0] prf_addr_t;

   // Slot in the reorder buffer
   typedef logic [`NCPU_ROB_AW-1:0] rob_id_t;

endpackage

// ==== ex/alu_exec.sv ====
`timescale 1ns/10ps
`include "ncpu_config.svh"

module alu_exec
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     ex_valid,
   output logic                     ex_ready,
   input  ncpu_isa_pkg::alu_opc_t   ex_opc,
   input  ncpu_pipe_pkg::prf_addr_t ex_prd,
   input  logic                     ex_prd_we,
   input  ncpu_pipe_pkg::rob_id_t   ex_rob_id,
   input  ncpu_isa_pkg::dword_t     ex_operand1,
   input  ncpu_isa_pkg::dword_t     ex_operand2,
   output logic                     wr_en,
   output ncpu_pipe_pkg::prf_addr_t wr_addr,
   output ncpu_isa_pkg::dword_t     wr_data,
   output logic                     res_valid,
   input  logic                     res_ready,
   output ncpu_isa_pkg::dword_t     res_data,
   output ncpu_pipe_pkg::prf_addr_t res_prd,
   output logic                     res_prd_we,
   output ncpu_pipe_pkg::rob_id_t   res_rob_id
);
   localparam int SHW = $clog2(`NCPU_DW);

   logic                 accept;
   logic [SHW-1:0]       shamt;
   ncpu_isa_pkg::dword_t alu_out;

   assign ex_ready = ~res_valid | res_ready;
   assign accept   = ex_valid & ex_ready;
   assign shamt    = ex_operand2[SHW-1:0];

   always_comb
   begin
      case (ex_opc)
         ncpu_isa_pkg::ALU_ADD: alu_out = ex_operand1 + ex_operand2;
         ncpu_isa_pkg::ALU_SUB: alu_out = ex_operand1 - ex_operand2;
         ncpu_isa_pkg::ALU_AND: alu_out = ex_operand1 & ex_operand2;
         ncpu_isa_pkg::ALU_OR:  alu_out = ex_operand1 | ex_operand2;
         ncpu_isa_pkg::ALU_XOR: alu_out = ex_operand1 ^ ex_operand2;
         ncpu_isa_pkg::ALU_SLL: alu_out = ex_operand1 << shamt;
         ncpu_isa_pkg::ALU_SRL: alu_out = ex_operand1 >> shamt;
         ncpu_isa_pkg::ALU_SLT:
            alu_out = {{(`NCPU_DW - 1){1'b0}}, $signed(ex_operand1) < $signed(ex_operand2)};
         default: alu_out = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
         res_valid <= 1'b0;
      else if (accept)
         res_valid <= 1'b1;
      else if (res_ready)
         res_valid <= 1'b0;
   end

   // Result register, held until transferred
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         res_data   <= alu_out;
         res_prd    <= ex_prd;
         res_prd_we <= ex_prd_we;
         res_rob_id <= ex_rob_id;
      end
   end

   // Write-back on the result transfer
   assign wr_en   = res_valid & res_ready & res_prd_we;
   assign wr_addr = res_prd;
   assign wr_data = res_data;

   // Stalled result keeps its data and tags
   a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid && !res_ready && !flush |=>
         res_valid && $stable({res_data, res_prd, res_prd_we, res_rob_id}));

endmodule

// ==== issue/issue_queue.sv ====
`timescale 1ns/10ps
`include "ncpu_config.svh"

module issue_queue
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     disp_valid,
   output logic                     disp_ready,
   input  ncpu_isa_pkg::alu_opc_t   disp_opc,
   input  ncpu_pipe_pkg::prf_addr_t disp_prs1,
   input  logic                     disp_prs1_re,
   input  ncpu_pipe_pkg::prf_addr_t disp_prs2,
   input  logic                     disp_prs2_re,
   input  ncpu_isa_pkg::dword_t     disp_imm,
   input  ncpu_pipe_pkg::prf_addr_t disp_prd,
   input  logic                     disp_prd_we,
   input  ncpu_pipe_pkg::rob_id_t   disp_rob_id,
   output logic                     ro_valid,
   input  logic                     ro_ready,
   output ncpu_isa_pkg::alu_opc_t   ro_opc,
   output ncpu_pipe_pkg::prf_addr_t ro_prs1,
   output logic                     ro_prs1_re,
   output ncpu_pipe_pkg::prf_addr_t ro_prs2,
   output logic                     ro_prs2_re,
   output ncpu_isa_pkg::dword_t     ro_imm,
   output ncpu_pipe_pkg::prf_addr_t ro_prd,
   output logic                     ro_prd_we,
   output ncpu_pipe_pkg::rob_id_t   ro_rob_id
);
   localparam int DEPTH = `NCPU_IQ_DEPTH;
   localparam int PW    = $clog2(DEPTH);
   localparam int CW    = $clog2(DEPTH + 1);

   // Entry storage, one array per field
   ncpu_isa_pkg::alu_opc_t    q_opc     [DEPTH];
   ncpu_pipe_pkg::prf_addr_t  q_prs1    [DEPTH];
   logic                      q_prs1_re [DEPTH];
   ncpu_pipe_pkg::prf_addr_t  q_prs2    [DEPTH];
   logic                      q_prs2_re [DEPTH];
   ncpu_isa_pkg::dword_t      q_imm     [DEPTH];
   ncpu_pipe_pkg::prf_addr_t  q_prd     [DEPTH];
   logic                      q_prd_we  [DEPTH];
   ncpu_pipe_pkg::rob_id_t    q_rob_id  [DEPTH];

   logic [PW-1:0]             rd_ptr;
   logic [PW-1:0]             wr_ptr;
   logic [CW-1:0]             count;
   logic                      push;
   logic                      pop;

   assign disp_ready = (count != CW'(DEPTH));
   assign ro_valid   = (count != '0);
   assign push       = disp_valid & disp_ready;
   assign pop        = ro_valid & ro_ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         q_opc[wr_ptr]     <= disp_opc;
         q_prs1[wr_ptr]    <= disp_prs1;
         q_prs1_re[wr_ptr] <= disp_prs1_re;
         q_prs2[wr_ptr]    <= disp_prs2;
         q_prs2_re[wr_ptr] <= disp_prs2_re;
         q_imm[wr_ptr]     <= disp_imm;
         q_prd[wr_ptr]     <= disp_prd;
         q_prd_we[wr_ptr]  <= disp_prd_we;
         q_rob_id[wr_ptr]  <= disp_rob_id;
      end
   end

   // Oldest entry goes to operand read
   assign ro_opc     = q_opc[rd_ptr];
   assign ro_prs1    = q_prs1[rd_ptr];
   assign ro_prs1_re = q_prs1_re[rd_ptr];
   assign ro_prs2    = q_prs2[rd_ptr];
   assign ro_prs2_re = q_prs2_re[rd_ptr];
   assign ro_imm     = q_imm[rd_ptr];
   assign ro_prd     = q_prd[rd_ptr];
   assign ro_prd_we  = q_prd_we[rd_ptr];
   assign ro_rob_id  = q_rob_id[rd_ptr];

   // Full queue without a pop leaves count and write pointer alone
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      count == CW'(DEPTH) && !pop && !flush |=>
         count == CW'(DEPTH) && wr_ptr == $past(wr_ptr));
   // Empty queue without a push leaves count and read pointer alone
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      count == '0 && !push && !flush |=>
         count == '0 && rd_ptr == $past(rd_ptr));
   a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
      count <= CW'(DEPTH));

endmodule

// ==== ncpu_ro.f ====
+incdir+common
common/ncpu_isa_pkg.sv
common/ncpu_pipe_pkg.sv
issue/issue_queue.sv
source/prf.sv
ro/operand_read.sv
ex/alu_exec.sv
source/ncpu_backend_top.sv
sim/tb_ncpu_backend.sv

// ==== ro/operand_read.sv ====
`timescale 1ns/10ps

module operand_read
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     ro_valid,
   output logic                     ro_ready,
   input  ncpu_isa_pkg::alu_opc_t   ro_opc,
   input  ncpu_pipe_pkg::prf_addr_t ro_prs1,
   input  logic                     ro_prs1_re,
   input  ncpu_pipe_pkg::prf_addr_t ro_prs2,
   input  logic                     ro_prs2_re,
   input  ncpu_isa_pkg::dword_t     ro_imm,
   input  ncpu_pipe_pkg::prf_addr_t ro_prd,
   input  logic                     ro_prd_we,
   input  ncpu_pipe_pkg::rob_id_t   ro_rob_id,
   output logic [1:0]               rd_en,
   output ncpu_pipe_pkg::prf_addr_t rd_addr1,
   output ncpu_pipe_pkg::prf_addr_t rd_addr2,
   input  ncpu_isa_pkg::dword_t     rd_data1,
   input  ncpu_isa_pkg::dword_t     rd_data2,
   output logic                     ex_valid,
   input  logic                     ex_ready,
   output ncpu_isa_pkg::alu_opc_t   ex_opc,
   output ncpu_pipe_pkg::prf_addr_t ex_prd,
   output logic                     ex_prd_we,
   output ncpu_pipe_pkg::rob_id_t   ex_rob_id,
   output ncpu_isa_pkg::dword_t     ex_operand1,
   output ncpu_isa_pkg::dword_t     ex_operand2
);
   logic                 p_ce;
   logic                 s1o_prs1_re;
   logic                 s1o_prs2_re;
   ncpu_isa_pkg::dword_t s1o_imm;

   // Bypassable buffer: accept while empty or while the current op leaves
   assign ro_ready = ~ex_valid | ex_ready;
   assign p_ce     = ro_valid & ro_ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
         ex_valid <= 1'b0;
      else if (p_ce)
         ex_valid <= 1'b1;
      else if (ex_ready)
         ex_valid <= 1'b0;
   end

   // Stage register
   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         ex_opc      <= ro_opc;
         ex_prd      <= ro_prd;
         ex_prd_we   <= ro_prd_we;
         ex_rob_id   <= ro_rob_id;
         s1o_prs1_re <= ro_prs1_re;
         s1o_prs2_re <= ro_prs2_re;
         s1o_imm     <= ro_imm;
      end
   end

   // Register file reads run in parallel with the stage register
   assign rd_en[0] = p_ce & ro_prs1_re;
   assign rd_en[1] = p_ce & ro_prs2_re;
   assign rd_addr1 = ro_prs1;
   assign rd_addr2 = ro_prs2;

   // Register data or immediate
   assign ex_operand1 = s1o_prs1_re ? rd_data1 : s1o_imm;
   assign ex_operand2 = s1o_prs2_re ? rd_data2 : s1o_imm;

   // Holds across the register file too, its read data must not move
   a_ex_stable: assert property (@(posedge clk) disable iff (!rst_n || flush)
      ex_valid && !ex_ready |=>
         $stable({ex_opc, ex_prd, ex_prd_we, ex_rob_id, ex_operand1, ex_operand2}));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_ncpu_backend -Mdir obj_dir -f ncpu_ro.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_ncpu_backend > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q -F '*** FAILED ***' "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== sim/tb_ncpu_backend.sv ====
`timescale 1ns/10ps
`include "ncpu_config.svh"

module tb_ncpu_backend;
   // Cycle budget of each test phase
   localparam int PH_RESET = 10;
   localparam int PH_IMM   = 30;
   localparam int PH_REG   = 60;
   localparam int PH_BP    = 140;
   localparam int PH_FLUSH = 50;
   localparam int LIMIT    = (PH_RESET + PH_IMM + PH_REG + PH_BP + PH_FLUSH) * 3 / 2;

   logic                     clk;
   logic                     rst_n;
   logic                     flush;
   logic                     disp_valid;
   logic                     disp_ready;
   ncpu_isa_pkg::alu_opc_t   disp_opc;
   ncpu_pipe_pkg::prf_addr_t disp_prs1;
   logic                     disp_prs1_re;
   ncpu_pipe_pkg::prf_addr_t disp_prs2;
   logic                     disp_prs2_re;
   ncpu_isa_pkg::dword_t     disp_imm;
   ncpu_pipe_pkg::prf_addr_t disp_prd;
   logic                     disp_prd_we;
   ncpu_pipe_pkg::rob_id_t   disp_rob_id;
   logic                     res_valid;
   logic                     res_ready;
   ncpu_isa_pkg::dword_t     res_data;
   ncpu_pipe_pkg::prf_addr_t res_prd;
   logic                     res_prd_we;
   ncpu_pipe_pkg::rob_id_t   res_rob_id;

   // Shadow register file and expected results in dispatch order
   ncpu_isa_pkg::dword_t     shadow [1 << `NCPU_PRF_AW];
   ncpu_isa_pkg::dword_t     exp_data [$];
   ncpu_pipe_pkg::rob_id_t   exp_rob [$];
   ncpu_pipe_pkg::prf_addr_t exp_prd [$];
   logic                     exp_we [$];
   ncpu_isa_pkg::dword_t     op_a;
   ncpu_isa_pkg::dword_t     op_b;
   ncpu_pipe_pkg::rob_id_t   rob_seq = '0;

   int          disp_count = 0;
   int          res_count = 0;
   int          dropped = 0;
   int          outstanding;
   int          cycles = 0;
   int          rdy_mode = 1;
   int unsigned seed;
   logic        first_disp = 1'b0;
   logic        post_flush = 1'b0;

   assign outstanding = disp_count - res_count - dropped;

   ncpu_backend_top dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abort_run();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
      assert (exp == got)
      else
      begin
         $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
         abort_run();
      end
   endtask

   // Reference ALU from the opcode definitions
   function automatic ncpu_isa_pkg::dword_t alu_model(input ncpu_isa_pkg::alu_opc_t opc,
                                                      input ncpu_isa_pkg::dword_t a,
                                                      input ncpu_isa_pkg::dword_t b);
      ncpu_isa_pkg::dword_t r;
      int                   sh;
      sh = int'(b[5:0]);
      case (opc)
         ncpu_isa_pkg::ALU_ADD: r = a + b;
         ncpu_isa_pkg::ALU_SUB: r = a + ~b + 64'd1;
         ncpu_isa_pkg::ALU_AND: r = a & b;
         ncpu_isa_pkg::ALU_OR:  r = a | b;
         ncpu_isa_pkg::ALU_XOR: r = a ^ b;
         ncpu_isa_pkg::ALU_SLL: r = a << sh;
         ncpu_isa_pkg::ALU_SRL: r = a >> sh;
         // Differing signs decide alone, else unsigned order
         ncpu_isa_pkg::ALU_SLT: r = (a[63] != b[63]) ? {63'd0, a[63]} : {63'd0, a < b};
         default: r = '0;
      endcase
      return r;
   endfunction

   function automatic ncpu_isa_pkg::dword_t random_word();
      return {$urandom, $urandom};
   endfunction

   function automatic ncpu_pipe_pkg::rob_id_t next_rob();
      rob_seq = rob_seq + 1'b1;
      return rob_seq;
   endfunction

   // Holds valid and payload until the monitor counts the transfer
   task automatic send_op(input ncpu_isa_pkg::alu_opc_t opc,
                          input ncpu_pipe_pkg::prf_addr_t prs1, input logic prs1_re,
                          input ncpu_pipe_pkg::prf_addr_t prs2, input logic prs2_re,
                          input ncpu_isa_pkg::dword_t imm,
                          input ncpu_pipe_pkg::prf_addr_t prd, input logic prd_we,
                          input ncpu_pipe_pkg::rob_id_t rob);
      int n;
      n            = disp_count;
      disp_valid   = 1'b1;
      disp_opc     = opc;
      disp_prs1    = prs1;
      disp_prs1_re = prs1_re;
      disp_prs2    = prs2;
      disp_prs2_re = prs2_re;
      disp_imm     = imm;
      disp_prd     = prd;
      disp_prd_we  = prd_we;
      disp_rob_id  = rob;
      while (disp_count == n)
      begin
         @(posedge clk);
         #2;
      end
      disp_valid = 1'b0;
   endtask

   task automatic send_random(input ncpu_pipe_pkg::rob_id_t rob);
      send_op(ncpu_isa_pkg::alu_opc_t'(3'($urandom_range(7, 0))),
              ncpu_pipe_pkg::prf_addr_t'(1 + $urandom_range(7, 0)), ($urandom % 2) == 1,
              ncpu_pipe_pkg::prf_addr_t'(1 + $urandom_range(7, 0)), ($urandom % 2) == 1,
              random_word(), ncpu_pipe_pkg::prf_addr_t'(40 + $urandom_range(7, 0)),
              ($urandom % 2) == 1, rob);
   endtask

   task automatic drain_pipe();
      while (outstanding != 0)
      begin
         @(posedge clk);
         #2;
      end
   endtask

   // Result sink, 0 stalls, 1 always ready, 2 random
   initial
   begin
      res_ready = 1'b0;
      forever
      begin
         @(posedge clk);
         #2;
         case (rdy_mode)
            0: res_ready = 1'b0;
            1: res_ready = 1'b1;
            default: res_ready = ($urandom % 2) == 1;
         endcase
      end
   end

   // Transfer monitor and scoreboard
   always @(posedge clk)
   begin
      if (rst_n && flush)
      begin
         dropped <= dropped + exp_data.size();
         exp_data.delete();
         exp_rob.delete();
         exp_prd.delete();
         exp_we.delete();
      end
      else if (rst_n)
      begin
         if (res_valid && res_ready)
         begin
            if (exp_data.size() == 0)
            begin
               $display("Result with ROB id %0d arrived with no op outstanding", res_rob_id);
               abort_run();
            end
            else
            begin
               check_value("res_rob_id", 64'(exp_rob[0]), 64'(res_rob_id));
               check_value("res_prd", 64'(exp_prd[0]), 64'(res_prd));
               check_value("res_prd_we", 64'(exp_we[0]), 64'(res_prd_we));
               check_value("res_data", exp_data[0], res_data);
               if (exp_we[0])
                  shadow[exp_prd[0]] = exp_data[0];
               void'(exp_data.pop_front());
               void'(exp_rob.pop_front());
               void'(exp_prd.pop_front());
               void'(exp_we.pop_front());
               res_count <= res_count + 1;
            end
         end
         if (disp_valid && disp_ready)
         begin
            op_a = disp_prs1_re ? shadow[disp_prs1] : disp_imm;
            op_b = disp_prs2_re ? shadow[disp_prs2] : disp_imm;
            exp_data.push_back(alu_model(disp_opc, op_a, op_b));
            exp_rob.push_back(disp_rob_id);
            exp_prd.push_back(disp_prd);
            exp_we.push_back(disp_prd_we);
            disp_count <= disp_count + 1;
            first_disp <= 1'b1;
         end
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT)
      begin
         $display("Timeout after %0d cycles, the pipeline stopped making progress", cycles);
         abort_run();
      end
   end

   a_idle_after_reset: assert property (@(posedge clk)
      rst_n && !first_disp |-> !res_valid && disp_ready)
      else
      begin
         $display("ERR t=%0t idle after reset exp res_valid=0 disp_ready=1 got %b %b",
                  $time, res_valid, disp_ready);
         abort_run();
      end

   a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid && !res_ready && !flush |=>
         res_valid && $stable({res_data, res_prd, res_prd_we, res_rob_id}))
      else
      begin
         $display("Result at t=%0t changed or vanished while stalled", $time);
         abort_run();
      end

   a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding >= 6 |-> !disp_ready && outstanding == 6)
      else
      begin
         $display("ERR t=%0t disp_ready exp=0 got=%b with %0d ops outstanding",
                  $time, disp_ready, outstanding);
         abort_run();
      end

   a_flushed_ids: assert property (@(posedge clk)
      post_flush && res_valid |-> res_rob_id >= 5'd24)
      else
      begin
         $display("Result with ROB id %0d from before the flush appeared", res_rob_id);
         abort_run();
      end

   initial
   begin
      seed         = $urandom(60112);
      rst_n        = 1'b0;
      flush        = 1'b0;
      disp_valid   = 1'b0;
      disp_opc     = ncpu_isa_pkg::ALU_ADD;
      disp_prs1    = '0;
      disp_prs1_re = 1'b0;
      disp_prs2    = '0;
      disp_prs2_re = 1'b0;
      disp_imm     = '0;
      disp_prd     = '0;
      disp_prd_we  = 1'b0;
      disp_rob_id  = '0;
      for (int i = 0; i < (1 << `NCPU_PRF_AW); i++)
         shadow[i] = '0;
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      repeat (3) @(posedge clk);
      #2;

      // Immediate with itself, every opcode
      for (int i = 0; i < 8; i++)
         send_op(ncpu_isa_pkg::alu_opc_t'(3'(i)), '0, 1'b0, '0, 1'b0, random_word(),
                 ncpu_pipe_pkg::prf_addr_t'(i + 20), 1'b0, next_rob());
      drain_pipe();

      // Fill r1..r8, then read them back
      for (int i = 1; i <= 8; i++)
         send_op(ncpu_isa_pkg::ALU_ADD, '0, 1'b0, '0, 1'b0, random_word(),
                 ncpu_pipe_pkg::prf_addr_t'(i), 1'b1, next_rob());
      drain_pipe();
      for (int i = 0; i < 8; i++)
         send_op(ncpu_isa_pkg::alu_opc_t'(3'(i)), ncpu_pipe_pkg::prf_addr_t'(1 + i),
                 (i % 3) != 1, ncpu_pipe_pkg::prf_addr_t'(1 + (i + 3) % 8), (i % 3) != 0,
                 random_word(), ncpu_pipe_pkg::prf_addr_t'(30), 1'b0, next_rob());
      drain_pipe();

      // Stalled sink fills every slot
      rdy_mode = 0;
      for (int i = 0; i < 6; i++)
         send_random(next_rob());
      repeat (2) @(posedge clk);
      #2;
      check_value("disp_ready", 64'd0, 64'(disp_ready));
      check_value("res_valid", 64'd1, 64'(res_valid));
      rdy_mode = 2;
      for (int i = 0; i < 30; i++)
         send_random(next_rob());
      drain_pipe();

      // Ops in flight at the flush must vanish, r60 stays unwritten
      rdy_mode = 0;
      for (int i = 0; i < 5; i++)
         send_op(ncpu_isa_pkg::ALU_ADD, '0, 1'b0, '0, 1'b0, random_word(),
                 ncpu_pipe_pkg::prf_addr_t'(60), 1'b1, ncpu_pipe_pkg::rob_id_t'(16 + i));
      repeat (2) @(posedge clk);
      #2;
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush      = 1'b0;
      post_flush = 1'b1;
      rdy_mode   = 1;
      check_value("res_valid", 64'd0, 64'(res_valid));
      for (int i = 0; i < 6; i++)
         send_op(ncpu_isa_pkg::alu_opc_t'(3'(i)), ncpu_pipe_pkg::prf_addr_t'(i == 0 ? 60 : i),
                 1'b1, ncpu_pipe_pkg::prf_addr_t'(40 + i), 1'b1, random_word(),
                 ncpu_pipe_pkg::prf_addr_t'(50), 1'b0, ncpu_pipe_pkg::rob_id_t'(24 + i));
      drain_pipe();

      // Every op retires except the 5 caught by the flush
      if (res_count == 66 && dropped == 5)
      begin
         $display("*** PASSED ***");
         $finish;
      end
      else
      begin
         $display("Ops lost or duplicated: %0d dispatched, %0d retired, %0d flushed",
                  disp_count, res_count, dropped);
         abort_run();
      end
   end

endmodule

// ==== source/ncpu_backend_top.sv ====
`timescale 1ns/10ps

module ncpu_backend_top
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     disp_valid,
   output logic                     disp_ready,
   input  ncpu_isa_pkg::alu_opc_t   disp_opc,
   input  ncpu_pipe_pkg::prf_addr_t disp_prs1,
   input  logic                     disp_prs1_re,
   input  ncpu_pipe_pkg::prf_addr_t disp_prs2,
   input  logic                     disp_prs2_re,
   input  ncpu_isa_pkg::dword_t     disp_imm,
   input  ncpu_pipe_pkg::prf_addr_t disp_prd,
   input  logic                     disp_prd_we,
   input  ncpu_pipe_pkg::rob_id_t   disp_rob_id,
   output logic                     res_valid,
   input  logic                     res_ready,
   output ncpu_isa_pkg::dword_t     res_data,
   output ncpu_pipe_pkg::prf_addr_t res_prd,
   output logic                     res_prd_we,
   output ncpu_pipe_pkg::rob_id_t   res_rob_id
);
   // Queue to operand read
   logic                     ro_valid;
   logic                     ro_ready;
   ncpu_isa_pkg::alu_opc_t   ro_opc;
   ncpu_pipe_pkg::prf_addr_t ro_prs1;
   logic                     ro_prs1_re;
   ncpu_pipe_pkg::prf_addr_t ro_prs2;
   logic                     ro_prs2_re;
   ncpu_isa_pkg::dword_t     ro_imm;
   ncpu_pipe_pkg::prf_addr_t ro_prd;
   logic                     ro_prd_we;
   ncpu_pipe_pkg::rob_id_t   ro_rob_id;

   // Register file ports
   logic [1:0]               rd_en;
   ncpu_pipe_pkg::prf_addr_t rd_addr1;
   ncpu_pipe_pkg::prf_addr_t rd_addr2;
   ncpu_isa_pkg::dword_t     rd_data1;
   ncpu_isa_pkg::dword_t     rd_data2;
   logic                     wr_en;
   ncpu_pipe_pkg::prf_addr_t wr_addr;
   ncpu_isa_pkg::dword_t     wr_data;

   // Operand read to ALU
   logic                     ex_valid;
   logic                     ex_ready;
   ncpu_isa_pkg::alu_opc_t   ex_opc;
   ncpu_pipe_pkg::prf_addr_t ex_prd;
   logic                     ex_prd_we;
   ncpu_pipe_pkg::rob_id_t   ex_rob_id;
   ncpu_isa_pkg::dword_t     ex_operand1;
   ncpu_isa_pkg::dword_t     ex_operand2;

   issue_queue u_iq
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush        (flush),
      .disp_valid   (disp_valid),
      .disp_ready   (disp_ready),
      .disp_opc     (disp_opc),
      .disp_prs1    (disp_prs1),
      .disp_prs1_re (disp_prs1_re),
      .disp_prs2    (disp_prs2),
      .disp_prs2_re (disp_prs2_re),
      .disp_imm     (disp_imm),
      .disp_prd     (disp_prd),
      .disp_prd_we  (disp_prd_we),
      .disp_rob_id  (disp_rob_id),
      .ro_valid     (ro_valid),
      .ro_ready     (ro_ready),
      .ro_opc       (ro_opc),
      .ro_prs1      (ro_prs1),
      .ro_prs1_re   (ro_prs1_re),
      .ro_prs2      (ro_prs2),
      .ro_prs2_re   (ro_prs2_re),
      .ro_imm       (ro_imm),
      .ro_prd       (ro_prd),
      .ro_prd_we    (ro_prd_we),
      .ro_rob_id    (ro_rob_id)
   );

   operand_read u_ro
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .ro_valid    (ro_valid),
      .ro_ready    (ro_ready),
      .ro_opc      (ro_opc),
      .ro_prs1     (ro_prs1),
      .ro_prs1_re  (ro_prs1_re),
      .ro_prs2     (ro_prs2),
      .ro_prs2_re  (ro_prs2_re),
      .ro_imm      (ro_imm),
      .ro_prd      (ro_prd),
      .ro_prd_we   (ro_prd_we),
      .ro_rob_id   (ro_rob_id),
      .rd_en       (rd_en),
      .rd_addr1    (rd_addr1),
      .rd_addr2    (rd_addr2),
      .rd_data1    (rd_data1),
      .rd_data2    (rd_data2),
      .ex_valid    (ex_valid),
      .ex_ready    (ex_ready),
      .ex_opc      (ex_opc),
      .ex_prd      (ex_prd),
      .ex_prd_we   (ex_prd_we),
      .ex_rob_id   (ex_rob_id),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2)
   );

   prf u_prf
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_en    (rd_en),
      .rd_addr1 (rd_addr1),
      .rd_addr2 (rd_addr2),
      .rd_data1 (rd_data1),
      .rd_data2 (rd_data2),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   alu_exec u_alu
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .ex_valid    (ex_valid),
      .ex_ready    (ex_ready),
      .ex_opc      (ex_opc),
      .ex_prd      (ex_prd),
      .ex_prd_we   (ex_prd_we),
      .ex_rob_id   (ex_rob_id),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .res_valid   (res_valid),
      .res_ready   (res_ready),
      .res_data    (res_data),
      .res_prd     (res_prd),
      .res_prd_we  (res_prd_we),
      .res_rob_id  (res_rob_id)
   );

endmodule

// ==== source/prf.sv ====
`timescale 1ns/10ps
`include "ncpu_config.svh"

module prf
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [1:0]               rd_en,
   input  ncpu_pipe_pkg::prf_addr_t rd_addr1,
   input  ncpu_pipe_pkg::prf_addr_t rd_addr2,
   output ncpu_isa_pkg::dword_t     rd_data1,
   output ncpu_isa_pkg::dword_t     rd_data2,
   input  logic                     wr_en,
   input  ncpu_pipe_pkg::prf_addr_t wr_addr,
   input  ncpu_isa_pkg::dword_t     wr_data
);
   localparam int NREGS = 1 << `NCPU_PRF_AW;

   ncpu_isa_pkg::dword_t regs [NREGS];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NREGS; i++)
            regs[i] <= '0;
      end
      else if (wr_en)
      begin
         regs[wr_addr] <= wr_data;
      end
   end

   // Read ports hold their data until the next enabled read
   always_ff @(posedge clk)
   begin
      if (rd_en[0])
      begin
         // Write-first when addresses collide
         if (wr_en && (wr_addr == rd_addr1))
            rd_data1 <= wr_data;
         else
            rd_data1 <= regs[rd_addr1];
      end
      if (rd_en[1])
      begin
         if (wr_en && (wr_addr == rd_addr2))
            rd_data2 <= wr_data;
         else
            rd_data2 <= regs[rd_addr2];
      end
   end

   // Operand read must stay idle during reset
   a_no_read_in_reset: assert property (@(posedge clk)
      !rst_n |-> rd_en == 2'b00);

endmodule
